// ==== Bender.yml ====
package:
  name: mm_ram

sources:
  - files:
      - logic/mem_map_pkg.sv
      - logic/addr_decoder.sv
      - logic/ram_byte_lane.sv
      - logic/read_mux.sv
      - logic/test_timer.sv
      - logic/mm_ram.sv

  - target: test
    files:
      - testbench/mm_ram_checker.sv
      - testbench/tb_mm_ram.sv

// ==== logic/addr_decoder.sv ====
/*
 * Decodes granted data-port requests into byte-lane, timer and
 * test-control actions. Every request is granted at once and answered
 * with a read-valid pulse one cycle later.
 */
`timescale 1ns/100ps
`default_nettype none

module addr_decoder
    import mem_map_pkg::*;
(
    input  logic      clk_i,
    input  logic      rst_ni,
    input  logic      req_i,
    input  mem_req_t  pkt_i,
    output logic      gnt_o,
    output logic      rvalid_o,
    output rsel_e     rsel_o,
    output lane_req_t lane_req_o [NUM_LANES],
    output timer_wr_t timer_wr_o,
    output logic      tests_passed_o,
    output logic      tests_failed_o
);

    logic  ram_hit;
    logic  cntrl_hit;
    logic  cntrl_wr;
    rsel_e rsel_d;

    // no back-pressure, the grant follows the request
    assign gnt_o = req_i;

    // either alias of the ram
    assign ram_hit = (pkt_i.addr < SRAM_LEN) ||
                     (pkt_i.addr >= SRAM_BASE && pkt_i.addr < SRAM_BASE + SRAM_LEN);

    assign cntrl_hit = pkt_i.addr >= CNTRL_BASE && pkt_i.addr < CNTRL_BASE + CNTRL_LEN;
    assign cntrl_wr  = req_i && pkt_i.we && cntrl_hit;

    always_comb begin
        for (int k = 0; k < NUM_LANES; k++) begin
            lane_req_o[k].en    = req_i && ram_hit;
            lane_req_o[k].we    = req_i && ram_hit && pkt_i.we && pkt_i.be[k];
            // clip upper bits and the byte offset
            lane_req_o[k].widx  = pkt_i.addr[RAM_ADDR_WIDTH-1:2];
            lane_req_o[k].wbyte = pkt_i.wdata[8*k +: 8];
        end
    end

    assign timer_wr_o.mask_we = req_i && pkt_i.we && (pkt_i.addr == TIMER_MASK_ADDR);
    assign timer_wr_o.cnt_we  = req_i && pkt_i.we && (pkt_i.addr == TIMER_CNT_ADDR);
    assign timer_wr_o.wdata   = pkt_i.wdata;

    // writes carry no read data
    always_comb begin
        rsel_d = RSEL_IDLE;
        if (req_i && !pkt_i.we) begin
            rsel_d = ram_hit ? RSEL_RAM : RSEL_UNMAP;
        end
    end

    always_ff @(posedge clk_i, negedge rst_ni) begin
        if (!rst_ni) begin
            rvalid_o       <= 1'b0;
            rsel_o         <= RSEL_IDLE;
            tests_passed_o <= 1'b0;
            tests_failed_o <= 1'b0;
        end else begin
            rvalid_o       <= req_i;
            rsel_o         <= rsel_d;
            tests_passed_o <= cntrl_wr && (pkt_i.wdata == TEST_PASS_VALUE);
            tests_failed_o <= cntrl_wr && (pkt_i.wdata != TEST_PASS_VALUE);
        end
    end

endmodule

`default_nettype wire

// ==== logic/mem_map_pkg.sv ====
/*
 * Memory map, widths and shared types of the data-port RAM block.
 * Imported by every RTL module of the block and by the testbench.
 */
`default_nettype none

package mem_map_pkg;

    // ram geometry
    localparam int unsigned RAM_ADDR_WIDTH = 12;
    localparam int unsigned NUM_LANES      = 4;

    typedef logic [31:0]               addr_t;
    typedef logic [31:0]               data_t;
    typedef logic [NUM_LANES-1:0]      be_t;
    typedef logic [7:0]                byte_t;
    typedef logic [RAM_ADDR_WIDTH-3:0] widx_t;
    typedef logic [4:0]                irq_id_t;

    // ram is visible at zero and mirrored at SRAM_BASE
    localparam addr_t SRAM_BASE = 32'h1C00_0000;
    localparam addr_t SRAM_LEN  = addr_t'(1) << RAM_ADDR_WIDTH;

    // test-control window, write F00D for pass
    localparam addr_t CNTRL_BASE      = 32'h1A10_4000;
    localparam addr_t CNTRL_LEN       = 32'h0000_1000;
    localparam data_t TEST_PASS_VALUE = 32'h0000_F00D;

    // countdown timer registers
    localparam addr_t   TIMER_MASK_ADDR = 32'h1A10_B000;
    localparam addr_t   TIMER_CNT_ADDR  = 32'h1A10_B004;
    localparam irq_id_t TIMER_IRQ_ID    = 5'd3;

    // request payload from the core data port
    typedef struct packed {
        addr_t addr;
        logic  we;
        be_t   be;
        data_t wdata;
    } mem_req_t;

    // per byte-lane access
    typedef struct packed {
        logic  en;
        logic  we;
        widx_t widx;
        byte_t wbyte;
    } lane_req_t;

    // register writes into the timer
    typedef struct packed {
        logic  mask_we;
        logic  cnt_we;
        data_t wdata;
    } timer_wr_t;

    // source of the read data in the response cycle
    typedef enum logic [1:0] {
        RSEL_IDLE,
        RSEL_RAM,
        RSEL_UNMAP
    } rsel_e;

endpackage

`default_nettype wire

// ==== logic/mm_ram.sv ====
/*
 * Memory-mapped RAM and peripheral block for the core data port.
 * Connects the address decoder, the byte-lane RAM, the read mux and the
 * test timer.
 */
`timescale 1ns/100ps
`default_nettype none

module mm_ram
    import mem_map_pkg::*;
(
    input  logic     clk_i,
    input  logic     rst_ni,

    input  logic     data_req_i,
    input  mem_req_t data_pkt_i,
    output logic     data_gnt_o,
    output logic     data_rvalid_o,
    output data_t    data_rdata_o,

    input  logic     irq_ack_i,
    input  irq_id_t  irq_id_i,
    output logic     irq_o,

    output logic     tests_passed_o,
    output logic     tests_failed_o
);

    lane_req_t lane_req   [NUM_LANES];
    byte_t     lane_rdata [NUM_LANES];
    rsel_e     rsel;
    timer_wr_t timer_wr;

    addr_decoder addr_decoder_i (
        .clk_i          ( clk_i          ),
        .rst_ni         ( rst_ni         ),
        .req_i          ( data_req_i     ),
        .pkt_i          ( data_pkt_i     ),
        .gnt_o          ( data_gnt_o     ),
        .rvalid_o       ( data_rvalid_o  ),
        .rsel_o         ( rsel           ),
        .lane_req_o     ( lane_req       ),
        .timer_wr_o     ( timer_wr       ),
        .tests_passed_o ( tests_passed_o ),
        .tests_failed_o ( tests_failed_o )
    );

    // one RAM per byte lane
    for (genvar k = 0; k < NUM_LANES; k++) begin : gen_lanes
        ram_byte_lane ram_byte_lane_i (
            .clk_i      ( clk_i         ),
            .lane_req_i ( lane_req[k]   ),
            .rdata_o    ( lane_rdata[k] )
        );
    end

    read_mux read_mux_i (
        .rsel_i       ( rsel         ),
        .lane_rdata_i ( lane_rdata   ),
        .rdata_o      ( data_rdata_o )
    );

    test_timer test_timer_i (
        .clk_i      ( clk_i     ),
        .rst_ni     ( rst_ni    ),
        .timer_wr_i ( timer_wr  ),
        .irq_ack_i  ( irq_ack_i ),
        .irq_id_i   ( irq_id_i  ),
        .irq_o      ( irq_o     )
    );

endmodule

`default_nettype wire

// ==== logic/ram_byte_lane.sv ====
/*
 * One byte lane of the data RAM. Synchronous, read data is registered
 * and appears one cycle after the enable.
 */
`timescale 1ns/100ps
`default_nettype none

module ram_byte_lane
    import mem_map_pkg::*;
(
    input  logic      clk_i,
    input  lane_req_t lane_req_i,
    output byte_t     rdata_o
);

    // one byte per word index
    byte_t mem [2**(RAM_ADDR_WIDTH-2)];

    always_ff @(posedge clk_i) begin
        if (lane_req_i.en) begin
            if (lane_req_i.we) begin
                mem[lane_req_i.widx] <= lane_req_i.wbyte;
            end else begin
                rdata_o <= mem[lane_req_i.widx];
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/read_mux.sv ====
/*
 * Builds the read word from the byte lanes and picks RAM data or zero
 * according to the registered read select of the decoder.
 */
`timescale 1ns/100ps
`default_nettype none

module read_mux
    import mem_map_pkg::*;
(
    input  rsel_e rsel_i,
    input  byte_t lane_rdata_i [NUM_LANES],
    output data_t rdata_o
);

    data_t ram_word;

    // lane 0 holds the lowest byte
    always_comb begin
        ram_word = '0;
        for (int k = 0; k < NUM_LANES; k++) begin
            ram_word[8*k +: 8] = lane_rdata_i[k];
        end
    end

    always_comb begin
        unique case (rsel_i)
            RSEL_RAM:   rdata_o = ram_word;
            RSEL_UNMAP: rdata_o = '0;
            default:    rdata_o = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== logic/test_timer.sv ====
/*
 * Countdown timer for test timeouts. Software writes the interrupt mask,
 * then a start count; the timer raises irq_o when the count runs out.
 */
`timescale 1ns/100ps
`default_nettype none

module test_timer
    import mem_map_pkg::*;
(
    input  logic      clk_i,
    input  logic      rst_ni,
    input  timer_wr_t timer_wr_i,
    input  logic      irq_ack_i,
    input  irq_id_t   irq_id_i,
    output logic      irq_o
);

    data_t mask_q;
    data_t cnt_q;

    always_ff @(posedge clk_i, negedge rst_ni) begin
        if (!rst_ni) begin
            mask_q <= '0;
            cnt_q  <= '0;
            irq_o  <= 1'b0;
        end else begin
            // mask write wins over count write
            if (timer_wr_i.mask_we) begin
                mask_q <= timer_wr_i.wdata;
            end else if (timer_wr_i.cnt_we) begin
                cnt_q <= timer_wr_i.wdata;
            end else begin
                if (cnt_q > 0) begin
                    cnt_q <= cnt_q - 1'b1;
                end

                // fires on the 1 to 0 step, only if unmasked
                if (cnt_q == 1 && mask_q[TIMER_IRQ_ID]) begin
                    irq_o <= 1'b1;
                end

                if (irq_ack_i && irq_id_i == TIMER_IRQ_ID) begin
                    irq_o <= 1'b0;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== mm_ram.f ====
logic/mem_map_pkg.sv
logic/addr_decoder.sv
logic/ram_byte_lane.sv
logic/read_mux.sv
logic/test_timer.sv
logic/mm_ram.sv
testbench/mm_ram_checker.sv
testbench/tb_mm_ram.sv

// ==== testbench/mm_ram_checker.sv ====
/*
 * Protocol assertions on the data port, test flags and timer interrupt.
 * Bound into every mm_ram instance.
 */
`timescale 1ns/100ps
`default_nettype none

module mm_ram_checker (
    input wire logic clk_i,
    input wire logic rst_ni,
    input wire logic data_req_i,
    input wire logic data_gnt_o,
    input wire logic data_rvalid_o,
    input wire logic tests_passed_o,
    input wire logic tests_failed_o,
    input wire logic irq_o
);

    // read by the testbench at the end of the run
    int unsigned fail_count = 0;

    a_gnt_follows_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
        data_gnt_o == data_req_i)
        else begin
            $error("grant differs from request");
            fail_count++;
        end

    // one rvalid per grant, exactly one cycle later
    a_rvalid_after_gnt: assert property (@(posedge clk_i) disable iff (!rst_ni)
        data_gnt_o |=> data_rvalid_o)
        else begin
            $error("no rvalid one cycle after grant");
            fail_count++;
        end

    a_no_stray_rvalid: assert property (@(posedge clk_i) disable iff (!rst_ni)
        !data_gnt_o |=> !data_rvalid_o)
        else begin
            $error("rvalid without a grant");
            fail_count++;
        end

    a_flags_exclusive: assert property (@(posedge clk_i) disable iff (!rst_ni)
        !(tests_passed_o && tests_failed_o))
        else begin
            $error("pass and fail flags high together");
            fail_count++;
        end

    a_irq_low_after_reset: assert property (@(posedge clk_i)
        $rose(rst_ni) |-> !irq_o)
        else begin
            $error("irq_o high right after reset");
            fail_count++;
        end

endmodule

bind mm_ram mm_ram_checker mm_ram_checker_i (.*);

`default_nettype wire

// ==== testbench/tb_mm_ram.sv ====
/*
 * Testbench for the data-port RAM block. Runs a table of RAM and unmapped
 * accesses against a shadow model, then the test-control and timer sequences.
 */
`timescale 1ns/100ps
`default_nettype none

module tb_mm_ram
    import mem_map_pkg::*;
();

    localparam int unsigned WAIT_LIMIT = 50;
    localparam int unsigned NUM_ROWS   = 21;
    localparam int unsigned TIMER_N    = 20;

    typedef struct packed {
        logic  we;
        logic  rnd;     // write data comes from $urandom
        logic  shadow;  // expected read data comes from the shadow model
        addr_t addr;
        be_t   be;
        data_t wdata;
        data_t exp;
    } row_t;

    logic     clk_i;
    logic     rst_ni;
    logic     data_req_i;
    mem_req_t data_pkt_i;
    logic     data_gnt_o;
    logic     data_rvalid_o;
    data_t    data_rdata_o;
    logic     irq_ack_i;
    irq_id_t  irq_id_i;
    logic     irq_o;
    logic     tests_passed_o;
    logic     tests_failed_o;

    row_t        stim [NUM_ROWS];
    data_t       shadow_mem [2**(RAM_ADDR_WIDTH-2)];
    int unsigned mismatches = 0;
    int unsigned timeouts = 0;

    mm_ram mm_ram_i (.*);

    initial begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    task automatic compare(input data_t actual, input data_t expected, input string msg);
        if (actual !== expected) begin
            $display("Fail at %0t ns: %s, got %h, expected %h", $time, msg, actual, expected);
            mismatches++;
        end
    endtask

    // ram window per the memory map, both aliases
    function automatic logic hits_ram(input addr_t addr);
        return (addr < 32'h1000) || (addr >= 32'h1C00_0000 && addr < 32'h1C00_1000);
    endfunction

    // called on a falling edge, returns on the falling edge that shows rvalid
    task automatic run_access(input mem_req_t pkt, output data_t rdata);
        int unsigned n;
        data_req_i = 1'b1;
        data_pkt_i = pkt;
        n = 0;
        @(posedge clk_i);
        while (!data_gnt_o && n < WAIT_LIMIT) begin
            @(posedge clk_i);
            n++;
        end
        if (!data_gnt_o) begin
            $display("Timeout: request to address %h was never granted", pkt.addr);
            timeouts++;
        end
        @(negedge clk_i);
        data_req_i = 1'b0;
        n = 0;
        while (!data_rvalid_o && n < WAIT_LIMIT) begin
            @(negedge clk_i);
            n++;
        end
        if (!data_rvalid_o) begin
            $display("Timeout: no read-valid for address %h", pkt.addr);
            timeouts++;
        end
        rdata = data_rdata_o;
    endtask

    task automatic write_word(input addr_t addr, input data_t wdata);
        data_t unused;
        run_access('{addr: addr, we: 1'b1, be: 4'hf, wdata: wdata}, unused);
    endtask

    initial begin
        mem_req_t pkt;
        data_t    rdata;
        data_t    expected;
        int unsigned n;

        void'($urandom(32'hc01d));
        rst_ni     = 1'b0;
        data_req_i = 1'b0;
        data_pkt_i = '0;
        irq_ack_i  = 1'b0;
        irq_id_i   = '0;

        stim = '{
            '{1'b1, 1'b0, 1'b0, 32'h0000_0000, 4'hf, 32'h1122_3344, 32'h0},
            '{1'b0, 1'b0, 1'b0, 32'h0000_0000, 4'hf, 32'h0, 32'h1122_3344},
            '{1'b1, 1'b1, 1'b0, 32'h0000_07fc, 4'hf, 32'h0, 32'h0},
            '{1'b0, 1'b0, 1'b1, 32'h0000_07fc, 4'hf, 32'h0, 32'h0},
            '{1'b1, 1'b0, 1'b0, 32'h0000_0ffc, 4'hf, 32'hdead_beef, 32'h0},
            '{1'b0, 1'b0, 1'b0, 32'h0000_0ffc, 4'hf, 32'h0, 32'hdead_beef},
            '{1'b1, 1'b0, 1'b0, 32'h0000_0000, 4'h5, 32'haabb_ccdd, 32'h0},
            '{1'b0, 1'b0, 1'b0, 32'h0000_0000, 4'hf, 32'h0, 32'h11bb_33dd},
            '{1'b1, 1'b1, 1'b0, 32'h0000_07fc, 4'hc, 32'h0, 32'h0},
            '{1'b0, 1'b0, 1'b1, 32'h0000_07fc, 4'hf, 32'h0, 32'h0},
            '{1'b1, 1'b0, 1'b0, 32'h1c00_0100, 4'hf, 32'hcafe_f00d, 32'h0},
            '{1'b0, 1'b0, 1'b0, 32'h0000_0100, 4'hf, 32'h0, 32'hcafe_f00d},
            '{1'b1, 1'b0, 1'b0, 32'h0000_0200, 4'hf, 32'h0bad_c0de, 32'h0},
            '{1'b0, 1'b0, 1'b0, 32'h1c00_0200, 4'hf, 32'h0, 32'h0bad_c0de},
            // just past either ram alias, unmapped
            '{1'b0, 1'b0, 1'b0, 32'h0000_1000, 4'hf, 32'h0, 32'h0},
            '{1'b0, 1'b0, 1'b0, 32'h1c00_1000, 4'hf, 32'h0, 32'h0},
            '{1'b1, 1'b0, 1'b0, 32'h0000_1000, 4'hf, 32'hffff_ffff, 32'h0},
            '{1'b1, 1'b0, 1'b0, 32'h1c00_1100, 4'hf, 32'hffff_ffff, 32'h0},
            '{1'b0, 1'b0, 1'b0, 32'h0000_0000, 4'hf, 32'h0, 32'h11bb_33dd},
            '{1'b0, 1'b0, 1'b0, 32'h0000_0100, 4'hf, 32'h0, 32'hcafe_f00d},
            '{1'b0, 1'b0, 1'b0, 32'h1a10_b004, 4'hf, 32'h0, 32'h0}
        };

        repeat (8) @(negedge clk_i);
        rst_ni = 1'b1;
        @(negedge clk_i);

        for (int i = 0; i < NUM_ROWS; i++) begin
            pkt = '{addr: stim[i].addr, we: stim[i].we, be: stim[i].be, wdata: stim[i].wdata};
            if (stim[i].rnd) begin
                pkt.wdata = $urandom();
            end
            run_access(pkt, rdata);
            if (pkt.we && hits_ram(pkt.addr)) begin
                for (int b = 0; b < 4; b++) begin
                    if (pkt.be[b]) begin
                        shadow_mem[pkt.addr[11:2]][8*b +: 8] = pkt.wdata[8*b +: 8];
                    end
                end
            end
            if (!pkt.we) begin
                expected = stim[i].shadow ? shadow_mem[pkt.addr[11:2]] : stim[i].exp;
                compare(rdata, expected, $sformatf("read data of row %0d", i));
            end
        end

        // test-control window, pass value then any other value
        write_word(CNTRL_BASE + 32'h10, 32'h0000_f00d);
        compare(tests_passed_o, 1'b1, "tests_passed_o after pass write");
        compare(tests_failed_o, 1'b0, "tests_failed_o after pass write");
        @(negedge clk_i);
        compare(tests_passed_o, 1'b0, "tests_passed_o longer than one cycle");
        write_word(CNTRL_BASE, 32'h0000_0bad);
        compare(tests_failed_o, 1'b1, "tests_failed_o after fail write");
        compare(tests_passed_o, 1'b0, "tests_passed_o after fail write");
        @(negedge clk_i);
        compare(tests_failed_o, 1'b0, "tests_failed_o longer than one cycle");

        // unmasked countdown
        write_word(TIMER_MASK_ADDR, 32'h1 << 3);
        write_word(TIMER_CNT_ADDR, TIMER_N);
        n = 0;
        while (!irq_o && n < TIMER_N + WAIT_LIMIT) begin
            @(negedge clk_i);
            n++;
        end
        if (!irq_o) begin
            $display("Timeout: timer interrupt never raised");
            timeouts++;
        end
        compare(n >= TIMER_N, 1'b1, $sformatf("irq_o raised after only %0d cycles", n));
        irq_ack_i = 1'b1;
        irq_id_i  = 5'd3;
        @(negedge clk_i);
        compare(irq_o, 1'b0, "irq_o after acknowledge");
        irq_ack_i = 1'b0;
        irq_id_i  = '0;

        // masked countdown stays silent
        write_word(TIMER_MASK_ADDR, 32'h0);
        write_word(TIMER_CNT_ADDR, TIMER_N);
        for (int i = 0; i < TIMER_N + 5; i++) begin
            @(negedge clk_i);
            compare(irq_o, 1'b0, "irq_o with mask clear");
        end

        repeat (2) @(negedge clk_i);
        $display("errors: %0d mismatches, %0d timeouts, %0d assertion failures",
                 mismatches, timeouts, mm_ram_i.mm_ram_checker_i.fail_count);
        if (mismatches + timeouts + mm_ram_i.mm_ram_checker_i.fail_count == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
